//--- alu.sv
module alu (
	input  cpu_pkg::alu_func_e func_i,
	input  cpu_pkg::data_t     a_i,
	input  cpu_pkg::data_t     b_i,
	input  logic               cin_i,
	output cpu_pkg::alu_res_t  res_o
);

	localparam int MSB = cpu_pkg::DATA_N - 1;

	cpu_pkg::data_t b_add;
	logic [cpu_pkg::DATA_N:0] sum;
	cpu_pkg::data_t y;
	logic c;
	logic v;

	// Subtract adds the complement, carry in acts as not borrow
	assign b_add = (func_i == cpu_pkg::SUB) ? ~b_i : b_i;
	assign sum = {1'b0, a_i} + {1'b0, b_add} + {{cpu_pkg::DATA_N{1'b0}}, cin_i};

	always_comb begin
		c = cin_i;
		v = 1'b0;
		case (func_i)
			cpu_pkg::ADD, cpu_pkg::SUB: begin
				y = sum[MSB:0];
				c = sum[cpu_pkg::DATA_N];
				// Operands agree in sign but the result does not
				v = (a_i[MSB] == b_add[MSB]) && (sum[MSB] != a_i[MSB]);
			end
			cpu_pkg::AND: y = a_i & b_i;
			cpu_pkg::OR: y = a_i | b_i;
			cpu_pkg::XOR: y = a_i ^ b_i;
			cpu_pkg::INC: y = a_i + 1'b1;
			cpu_pkg::DEC: y = a_i - 1'b1;
			default: y = b_i;
		endcase
	end

	always_comb begin
		res_o.data = y;
		res_o.c = c;
		res_o.z = (y == '0);
		res_o.n = y[MSB];
		res_o.v = v;
	end

endmodule

//--- cpu.f
cpu_pkg.sv
alu.sv
status_reg.sv
pc_unit.sv
idec.sv
sequencer.sv
cpu.sv
cpu_tb.sv

//--- cpu.sv
module cpu #(
	parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              rdy_i,
	input  cpu_pkg::data_t    rdata_i,
	output cpu_pkg::mem_req_t mem_o,
	output logic              dbg_o
);

	cpu_pkg::opcode_u op;
	cpu_pkg::exec_ctl_t ctl;
	cpu_pkg::addr_mode_e mode;

	cpu_pkg::alu_func_e alu_func;
	cpu_pkg::data_t alu_a;
	cpu_pkg::data_t alu_b;
	cpu_pkg::alu_res_t res;

	cpu_pkg::data_t p;
	logic flag_en;

	cpu_pkg::addr_t pc;
	logic pc_inc;
	logic pc_load;
	logic pc_branch;
	cpu_pkg::addr_t load_addr;
	cpu_pkg::data_t offset;

	idec idec0 (.op_i(op), .ctl_o(ctl), .mode_o(mode));

	sequencer seq0 (
		.clk_i, .reset_i, .rdy_i, .rdata_i,
		.ctl_i(ctl), .mode_i(mode), .op_o(op),
		.p_i(p), .res_i(res),
		.alu_func_o(alu_func), .alu_a_o(alu_a), .alu_b_o(alu_b),
		.flag_en_o(flag_en),
		.pc_i(pc), .pc_inc_o(pc_inc), .pc_load_o(pc_load), .pc_branch_o(pc_branch),
		.load_addr_o(load_addr), .offset_o(offset),
		.mem_o, .dbg_o
	);

	// Carry in always comes straight from the status register
	alu alu0 (
		.func_i(alu_func), .a_i(alu_a), .b_i(alu_b),
		.cin_i(p[cpu_pkg::STATUS_C]),
		.res_o(res)
	);

	status_reg p0 (
		.clk_i, .reset_i,
		.en_i(flag_en), .res_i(res),
		.mask_i(ctl.flag_mask), .set_c_i(ctl.set_c), .clr_c_i(ctl.clr_c),
		.p_o(p)
	);

	pc_unit #(.RESET_PC(RESET_PC)) pc0 (
		.clk_i, .reset_i,
		.inc_i(pc_inc),
		.load_i(pc_load), .load_addr_i(load_addr),
		.branch_i(pc_branch), .offset_i(offset),
		.pc_o(pc)
	);

endmodule

//--- cpu_cases.txt
// Words 000-0FF: program bytes from RESET_PC; 100: store count
// 101 on: store address then store data; 1FF: BRK address
@000
A9 12 8D 00 03 AE F0 02 8E 01 03 A0 7F 8C 02 03
18 A9 70 69 20 8D 03 03 38 6D F1 02 8D 04 03
A9 00 69 00 8D 05 03 38 A9 50 E9 10 8D 06 03
18 E9 41 8D 07 03 A9 00 69 00 8D 08 03
A9 3C 2D F1 02 8D 09 03 0D F2 02 8D 0A 03 4D F3 02 8D 0B 03
A2 FF E8 8E 0C 03 CA 8A 8D 0D 03 A9 5A AA E8 8E 0E 03
C8 8C 0F 03
// Branch markers, then JMP over a gap
A9 00 F0 05 A9 EE 8D 10 03 D0 05 A9 11 8D 10 03
D0 03 8D 11 03 38 90 03 B0 03 8D 11 03
18 B0 02 90 02 A9 EE 8E 11 03
4C 95 02 8D 12 03 00 00 00
A9 77 8D 12 03 88 8C 13 03 00
@0F0
3C F0 0F 55
@100
0014
0300 12 0301 3C 0302 7F 0303 90
0304 81 0305 01 0306 40 0307 FE
0308 00 0309 30 030A 3F 030B 6A
030C 00 030D FF 030E 5B 030F 80
0310 11 0311 5B 0312 77 0313 7F
@1FF
029E

//--- cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_N = 8;
	localparam int ADDR_N = 16;

	typedef logic [DATA_N - 1:0] data_t;
	typedef logic [ADDR_N - 1:0] addr_t;

	typedef enum logic [3:0] {PASS_B, ADD, SUB, AND, OR, XOR, INC, DEC} alu_func_e;

	// Status register bit positions
	localparam int STATUS_C = 0;
	localparam int STATUS_Z = 1;
	localparam int STATUS_I = 2;
	localparam int STATUS_R = 5;
	localparam int STATUS_V = 6;
	localparam int STATUS_N = 7;

	// Flag update mask
	localparam int MASK_C = 0;
	localparam int MASK_Z = 1;
	localparam int MASK_V = 2;
	localparam int MASK_N = 3;
	localparam logic [3:0] FLAGS_NZ = 4'b1010;
	localparam logic [3:0] FLAGS_NZCV = 4'b1111;

	typedef struct packed {
		logic [2:0] aaa;
		logic [2:0] bbb;
		logic [1:0] cc;
	} op_fields_t;

	// Same instruction byte, raw or split into group fields
	typedef union packed {
		data_t raw;
		op_fields_t f;
	} opcode_u;

	typedef enum logic [2:0] {IMPLIED, IMMEDIATE, ABSOLUTE, RELATIVE, ILLEGAL} addr_mode_e;

	typedef enum logic [1:0] {SRC_A, SRC_X, SRC_Y, SRC_ZERO} src_e;
	typedef enum logic [1:0] {DST_NONE, DST_A, DST_X, DST_Y} dst_e;

	typedef struct packed {
		alu_func_e alu_func;
		src_e src_a;
		logic src_mem;
		dst_e dst;
		logic store;
		logic [3:0] flag_mask;
		logic set_c;
		logic clr_c;
		logic branch;
		// Bit 1 picks Z over C, bit 0 is the value that takes the branch
		logic [1:0] br_cond;
		logic jump;
		logic halt;
	} exec_ctl_t;

	typedef struct packed {
		data_t data;
		logic c;
		logic z;
		logic n;
		logic v;
	} alu_res_t;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic we;
	} mem_req_t;

endpackage

//--- cpu_tb.sv
module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam cpu_pkg::addr_t RESET_PC = 16'h0200;
	localparam int STEP_TIMEOUT = 400;
	localparam int QUIET_CYCLES = 60;

	logic clk_i;
	logic reset_i;
	logic rdy_i;
	cpu_pkg::data_t rdata_i;
	cpu_pkg::mem_req_t mem_o;
	logic dbg_o;

	cpu_pkg::data_t mem [0:65535];
	logic [15:0] cases_mem [0:511];
	cpu_pkg::addr_t wr_addr_q[$];
	cpu_pkg::data_t wr_data_q[$];
	logic [31:0] lfsr;

	cpu #(.RESET_PC(RESET_PC)) i_cpu (
		.clk_i, .reset_i, .rdy_i, .rdata_i, .mem_o, .dbg_o
	);

	always #2 clk_i = ~clk_i;

	// Asynchronous read port
	assign rdata_i = mem[mem_o.addr];

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// Ready is low only when both bits taken are zero
	always @(posedge clk_i) begin
		logic b0;
		logic b1;
		#0.5;
		b0 = lfsr[0];
		lfsr = lfsr_next(lfsr);
		b1 = lfsr[0];
		lfsr = lfsr_next(lfsr);
		rdy_i <= b0 | b1;
	end

	// Memory commits writes on ready edges and logs them
	always @(posedge clk_i) begin
		if (!reset_i && rdy_i && mem_o.we) begin
			mem[mem_o.addr] <= mem_o.wdata;
			wr_addr_q.push_back(mem_o.addr);
			wr_data_q.push_back(mem_o.wdata);
		end
	end

	task automatic fail_run();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_addr(input string name, input cpu_pkg::addr_t got,
			input cpu_pkg::addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_data(input string name, input cpu_pkg::data_t got,
			input cpu_pkg::data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic wait_store(input int idx);
		int cyc;
		cyc = 0;
		while (wr_addr_q.size() == 0 && !dbg_o && cyc < STEP_TIMEOUT) begin
			@(negedge clk_i);
			cyc++;
		end
		if (wr_addr_q.size() == 0) begin
			if (dbg_o)
				$display("Core halted before expected store %0d", idx);
			else
				$display("Timed out waiting for expected store %0d", idx);
			fail_run();
		end
	endtask

	task automatic wait_halt();
		int cyc;
		cyc = 0;
		while (!dbg_o && cyc < STEP_TIMEOUT) begin
			@(negedge clk_i);
			cyc++;
		end
		if (!dbg_o) begin
			$display("Timed out waiting for the core to halt at BRK");
			fail_run();
		end
	endtask

	initial begin
		int n_stores;
		cpu_pkg::addr_t halt_addr;
		clk_i = 1'b0;
		reset_i = 1'b1;
		rdy_i = 1'b1;
		lfsr = 32'h1dfa;
		for (int i = 0; i < 65536; i++)
			mem[i] = cpu_pkg::data_t'(i[15:8] ^ i[7:0] ^ 8'hA5);
		$readmemh("cpu_cases.txt", cases_mem);
		for (int i = 0; i < 256; i++)
			if (!$isunknown(cases_mem[i]))
				mem[RESET_PC + i] = cases_mem[i][7:0];
		n_stores = cases_mem[256];
		halt_addr = cases_mem[511];

		repeat (10) @(posedge clk_i);
		#0.5;
		reset_i = 1'b0;
		@(negedge clk_i);
		check_data("dbg_o", {7'b0, dbg_o}, 8'h00);
		check_data("mem_o.we", {7'b0, mem_o.we}, 8'h00);

		for (int k = 0; k < n_stores; k++) begin
			wait_store(k);
			check_addr("mem_o.addr", wr_addr_q.pop_front(), cases_mem[257 + 2 * k]);
			check_data("mem_o.wdata", wr_data_q.pop_front(), cases_mem[258 + 2 * k][7:0]);
		end

		wait_halt();
		check_addr("mem_o.addr", mem_o.addr, halt_addr + 1'b1);
		repeat (QUIET_CYCLES) @(negedge clk_i);
		if (wr_addr_q.size() != 0) begin
			$display("Unexpected write to %h after the last expected store", wr_addr_q[0]);
			$display("TB FAILED");
			$fatal(1);
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

//--- idec.sv
module idec (
	input  cpu_pkg::opcode_u    op_i,
	output cpu_pkg::exec_ctl_t  ctl_o,
	output cpu_pkg::addr_mode_e mode_o
);

	cpu_pkg::exec_ctl_t ctl;
	cpu_pkg::addr_mode_e mode;
	cpu_pkg::addr_mode_e grp_mode;
	cpu_pkg::src_e xy_src;
	cpu_pkg::dst_e xy_dst;

	function automatic cpu_pkg::exec_ctl_t reg_op(cpu_pkg::alu_func_e func,
			cpu_pkg::src_e src, cpu_pkg::dst_e dst);
		cpu_pkg::exec_ctl_t c;
		c = '0;
		c.alu_func = func;
		c.src_a = src;
		c.dst = dst;
		c.flag_mask = cpu_pkg::FLAGS_NZ;
		return c;
	endfunction

	// ALU group has immediate at bbb 010, the X/Y groups at 000
	always_comb begin
		if (op_i.f.bbb == 3'b011)
			grp_mode = cpu_pkg::ABSOLUTE;
		else if (op_i.f.cc == 2'b01 && op_i.f.bbb == 3'b010)
			grp_mode = cpu_pkg::IMMEDIATE;
		else if (op_i.f.cc != 2'b01 && op_i.f.bbb == 3'b000)
			grp_mode = cpu_pkg::IMMEDIATE;
		else
			grp_mode = cpu_pkg::ILLEGAL;
	end

	assign xy_src = (op_i.f.cc == 2'b10) ? cpu_pkg::SRC_X : cpu_pkg::SRC_Y;
	assign xy_dst = (op_i.f.cc == 2'b10) ? cpu_pkg::DST_X : cpu_pkg::DST_Y;

	always_comb begin
		// All zero is a pass with no register or flag write
		ctl = '0;
		mode = cpu_pkg::IMPLIED;
		case (op_i.raw)
			8'h00: ctl.halt = 1'b1;
			8'h18: ctl.clr_c = 1'b1;
			8'h38: ctl.set_c = 1'b1;
			8'hE8: ctl = reg_op(cpu_pkg::INC, cpu_pkg::SRC_X, cpu_pkg::DST_X);
			8'hC8: ctl = reg_op(cpu_pkg::INC, cpu_pkg::SRC_Y, cpu_pkg::DST_Y);
			8'hCA: ctl = reg_op(cpu_pkg::DEC, cpu_pkg::SRC_X, cpu_pkg::DST_X);
			8'h88: ctl = reg_op(cpu_pkg::DEC, cpu_pkg::SRC_Y, cpu_pkg::DST_Y);
			8'hAA: ctl = reg_op(cpu_pkg::PASS_B, cpu_pkg::SRC_A, cpu_pkg::DST_X);
			8'h8A: ctl = reg_op(cpu_pkg::PASS_B, cpu_pkg::SRC_X, cpu_pkg::DST_A);
			8'h4C: begin
				ctl.jump = 1'b1;
				mode = cpu_pkg::ABSOLUTE;
			end
			8'h90, 8'hB0, 8'hD0, 8'hF0: begin
				ctl.branch = 1'b1;
				ctl.br_cond = op_i.f.aaa[1:0];
				mode = cpu_pkg::RELATIVE;
			end
			default: begin
				mode = grp_mode;
				case (op_i.f.cc)
					2'b01: begin
						ctl = reg_op(cpu_pkg::PASS_B, cpu_pkg::SRC_A, cpu_pkg::DST_A);
						ctl.src_mem = 1'b1;
						case (op_i.f.aaa)
							3'b000: ctl.alu_func = cpu_pkg::OR;
							3'b001: ctl.alu_func = cpu_pkg::AND;
							3'b010: ctl.alu_func = cpu_pkg::XOR;
							3'b011: begin
								ctl.alu_func = cpu_pkg::ADD;
								ctl.flag_mask = cpu_pkg::FLAGS_NZCV;
							end
							3'b100: begin
								ctl = '0;
								ctl.store = 1'b1;
							end
							3'b101: ctl.alu_func = cpu_pkg::PASS_B;
							3'b111: begin
								ctl.alu_func = cpu_pkg::SUB;
								ctl.flag_mask = cpu_pkg::FLAGS_NZCV;
							end
							default: mode = cpu_pkg::ILLEGAL;
						endcase
					end
					2'b00, 2'b10: begin
						if (op_i.f.aaa == 3'b100) begin
							ctl.src_a = xy_src;
							ctl.store = 1'b1;
						end else if (op_i.f.aaa == 3'b101) begin
							ctl = reg_op(cpu_pkg::PASS_B, cpu_pkg::SRC_A, xy_dst);
							ctl.src_mem = 1'b1;
						end else begin
							mode = cpu_pkg::ILLEGAL;
						end
					end
					default: mode = cpu_pkg::ILLEGAL;
				endcase
			end
		endcase
		// Stores have no immediate form
		if (ctl.store && mode == cpu_pkg::IMMEDIATE)
			mode = cpu_pkg::ILLEGAL;
	end

	assign ctl_o = ctl;
	assign mode_o = mode;

endmodule

//--- pc_unit.sv
module pc_unit #(
	parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
	input  logic           clk_i,
	input  logic           reset_i,
	input  logic           inc_i,
	input  logic           load_i,
	input  cpu_pkg::addr_t load_addr_i,
	input  logic           branch_i,
	input  cpu_pkg::data_t offset_i,
	output cpu_pkg::addr_t pc_o
);

	cpu_pkg::addr_t pc;
	cpu_pkg::addr_t pc_seq;
	cpu_pkg::addr_t offset_ext;

	// Branch target counts from the byte past the operand
	assign pc_seq = pc + 1'b1;
	assign offset_ext = {{(cpu_pkg::ADDR_N - cpu_pkg::DATA_N){offset_i[cpu_pkg::DATA_N - 1]}},
		offset_i};

	always_ff @(posedge clk_i) begin
		if (reset_i)
			pc <= RESET_PC;
		else if (load_i)
			pc <= load_addr_i;
		else if (branch_i)
			pc <= pc_seq + offset_ext;
		else if (inc_i)
			pc <= pc_seq;
	end

	assign pc_o = pc;

endmodule

//--- sequencer.sv
module sequencer (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                rdy_i,
	input  cpu_pkg::data_t      rdata_i,
	input  cpu_pkg::exec_ctl_t  ctl_i,
	input  cpu_pkg::addr_mode_e mode_i,
	output cpu_pkg::opcode_u    op_o,
	input  cpu_pkg::data_t      p_i,
	input  cpu_pkg::alu_res_t   res_i,
	output cpu_pkg::alu_func_e  alu_func_o,
	output cpu_pkg::data_t      alu_a_o,
	output cpu_pkg::data_t      alu_b_o,
	output logic                flag_en_o,
	input  cpu_pkg::addr_t      pc_i,
	output logic                pc_inc_o,
	output logic                pc_load_o,
	output logic                pc_branch_o,
	output cpu_pkg::addr_t      load_addr_o,
	output cpu_pkg::data_t      offset_o,
	output cpu_pkg::mem_req_t   mem_o,
	output logic                dbg_o
);

	typedef enum logic [3:0] {FETCH, DISPATCH, OPER, ADL, ADH, MEM, EXEC, WR, HALT} state_e;

	state_e state;
	state_e cur;
	state_e next;
	cpu_pkg::opcode_u ir;
	cpu_pkg::data_t a;
	cpu_pkg::data_t x;
	cpu_pkg::data_t y;
	cpu_pkg::data_t adl;
	cpu_pkg::data_t adh;
	cpu_pkg::data_t oper;
	cpu_pkg::data_t src;
	logic br_flag;
	logic taken;

	// Cycle after fetch takes its role from the addressing mode
	always_comb begin
		cur = state;
		if (state == DISPATCH) begin
			case (mode_i)
				cpu_pkg::IMPLIED: cur = EXEC;
				cpu_pkg::IMMEDIATE, cpu_pkg::RELATIVE: cur = OPER;
				cpu_pkg::ABSOLUTE: cur = ADL;
				default: cur = HALT;
			endcase
		end
	end

	always_comb begin
		case (cur)
			FETCH: next = DISPATCH;
			OPER: next = ctl_i.branch ? FETCH : EXEC;
			ADL: next = ADH;
			ADH: begin
				if (ctl_i.jump)
					next = FETCH;
				else if (ctl_i.store)
					next = WR;
				else
					next = MEM;
			end
			MEM: next = EXEC;
			EXEC: next = ctl_i.halt ? HALT : FETCH;
			WR: next = FETCH;
			default: next = HALT;
		endcase
	end

	always_comb begin
		case (ctl_i.src_a)
			cpu_pkg::SRC_A: src = a;
			cpu_pkg::SRC_X: src = x;
			cpu_pkg::SRC_Y: src = y;
			cpu_pkg::SRC_ZERO: src = '0;
		endcase
	end

	assign br_flag = ctl_i.br_cond[1] ? p_i[cpu_pkg::STATUS_Z] : p_i[cpu_pkg::STATUS_C];
	assign taken = ctl_i.branch && (br_flag == ctl_i.br_cond[0]);

	assign op_o = ir;
	assign alu_func_o = ctl_i.alu_func;
	assign alu_a_o = src;
	// Register ops pass the source register through B
	assign alu_b_o = ctl_i.src_mem ? oper : src;
	assign flag_en_o = rdy_i && (cur == EXEC);

	// Load and branch win over increment inside pc_unit
	assign pc_inc_o = rdy_i && (cur inside {FETCH, OPER, ADL, ADH});
	assign pc_load_o = rdy_i && (cur == ADH) && ctl_i.jump;
	assign pc_branch_o = rdy_i && (cur == OPER) && taken;
	assign load_addr_o = {rdata_i, adl};
	assign offset_o = rdata_i;
	assign dbg_o = (state == HALT);

	always_comb begin
		mem_o.addr = (cur == MEM || cur == WR) ? {adh, adl} : pc_i;
		mem_o.wdata = src;
		mem_o.we = (cur == WR);
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= FETCH;
			ir <= '0;
			a <= '0;
			x <= '0;
			y <= '0;
		end else if (rdy_i) begin
			state <= next;
			if (cur == FETCH)
				ir.raw <= rdata_i;
			if (cur == EXEC) begin
				case (ctl_i.dst)
					cpu_pkg::DST_A: a <= res_i.data;
					cpu_pkg::DST_X: x <= res_i.data;
					cpu_pkg::DST_Y: y <= res_i.data;
					default: ;
				endcase
			end
		end
	end

	// Address and operand latches
	always_ff @(posedge clk_i) begin
		if (rdy_i) begin
			if (cur == ADL)
				adl <= rdata_i;
			if (cur == ADH)
				adh <= rdata_i;
			if (cur == OPER || cur == MEM)
				oper <= rdata_i;
		end
	end

endmodule

//--- status_reg.sv
module status_reg (
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              en_i,
	input  cpu_pkg::alu_res_t res_i,
	input  logic [3:0]        mask_i,
	input  logic              set_c_i,
	input  logic              clr_c_i,
	output cpu_pkg::data_t    p_o
);

	localparam cpu_pkg::data_t P_RESET =
		cpu_pkg::data_t'((1 << cpu_pkg::STATUS_I) | (1 << cpu_pkg::STATUS_R));

	cpu_pkg::data_t p;
	cpu_pkg::data_t flags;
	cpu_pkg::data_t mask;
	cpu_pkg::data_t p_next;

	// Move ALU flags and their mask onto status bit positions
	always_comb begin
		flags = '0;
		flags[cpu_pkg::STATUS_C] = res_i.c;
		flags[cpu_pkg::STATUS_Z] = res_i.z;
		flags[cpu_pkg::STATUS_V] = res_i.v;
		flags[cpu_pkg::STATUS_N] = res_i.n;
		mask = '0;
		mask[cpu_pkg::STATUS_C] = mask_i[cpu_pkg::MASK_C];
		mask[cpu_pkg::STATUS_Z] = mask_i[cpu_pkg::MASK_Z];
		mask[cpu_pkg::STATUS_V] = mask_i[cpu_pkg::MASK_V];
		mask[cpu_pkg::STATUS_N] = mask_i[cpu_pkg::MASK_N];
		p_next = (p & ~mask) | (flags & mask);
		if (set_c_i)
			p_next[cpu_pkg::STATUS_C] = 1'b1;
		if (clr_c_i)
			p_next[cpu_pkg::STATUS_C] = 1'b0;
		p_next[cpu_pkg::STATUS_R] = 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			p <= P_RESET;
		else if (en_i)
			p <= p_next;
	end

	assign p_o = p;

endmodule
